// ==== project.f ====
+incdir+src
+incdir+test
src/eth_rx_pkg.sv
src/frame_sync.sv
src/header_extract.sv
src/fcs_strip.sv
src/fcs_check.sv
src/eth_rx_top.sv
test/eth_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the eth_rx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module eth_rx_tb -o eth_rx_sim

./obj_dir/eth_rx_sim > sim.log 2>&1
cat sim.log

# pass only if the testbench reported success
grep -q "Everything OK" sim.log

// ==== src/eth_rx_defines.svh ====
`ifndef ETH_RX_DEFINES_SVH
`define ETH_RX_DEFINES_SVH

////////////////////////////////////////////////////////////
// preamble and start delimiters
////////////////////////////////////////////////////////////
`define PREAMBLE_BYTE   8'h55
`define SFD_BYTE        8'hD5

// express frame start codes
`define SMD_S0          8'hE6
`define SMD_S1          8'h4C
`define SMD_S2          8'h7F
`define SMD_S3          8'hB3

// continuation codes followed by a fragment count byte
`define SMD_C0          8'h61
`define SMD_C1          8'h52
`define SMD_C2          8'h9E
`define SMD_C3          8'h2A

// 0x55 bytes expected ahead of the decision byte
`define PREAMBLE_MIN    6

////////////////////////////////////////////////////////////
// frame layout and CRC
////////////////////////////////////////////////////////////
`define MAC_BYTES       6
`define HDR_BYTES       14
`define FCS_BYTES       4

`define CRC_INIT        32'hFFFF_FFFF
`define CRC_POLY_REFL   32'hEDB8_8320
// fragment marker folded into the FCS
`define MCRC_XOR        32'h0000_FFFF

// counters, byte index and payload length
`define CNT_W           16

`endif

// ==== src/eth_rx_pkg.sv ====
package eth_rx_pkg;

    // receive framing states
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        PREAMBLE = 3'd1,
        PRE_LAST = 3'd2,
        FRAG     = 3'd3,
        MAC_BODY = 3'd4,
        DISCARD  = 3'd5
    } rx_state_e;

    // checksum verdict
    // mcrc marks a preempted fragment, none with the error strobe is a bad FCS
    typedef enum logic [1:0] {
        CRC_NONE  = 2'b00,
        CRC_FINAL = 2'b01,
        CRC_MCRC  = 2'b10
    } crc_kind_e;

endpackage

// ==== src/eth_rx_top.sv ====
`timescale 1ns/10ps
`include "eth_rx_defines.svh"

module eth_rx_top import eth_rx_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [7:0]          i_rx_data,
    input  logic                i_rx_valid,
    output logic [47:0]         o_dst_mac,
    output logic                o_dst_vld,
    output logic [47:0]         o_src_mac,
    output logic                o_src_vld,
    output logic [15:0]         o_eth_type,
    output logic                o_type_vld,
    output logic [7:0]          o_delim,
    output logic                o_delim_vld,
    output logic [7:0]          o_frag_cnt,
    output logic                o_frag_vld,
    output logic [7:0]          o_pay_data,
    output logic                o_pay_vld,
    output logic                o_pay_last,
    output logic [`CNT_W-1:0]   o_pay_len,
    output logic                o_pay_len_vld,
    output crc_kind_e           o_crc_kind,
    output logic                o_crc_err,
    output logic [`CNT_W-1:0]   o_rx_frames_cnt,
    output logic [`CNT_W-1:0]   o_err_crc_cnt
);

    // MAC-layer byte stream
    logic [7:0]             mac_byte;
    logic                   mac_vld;
    logic [`CNT_W-1:0]      mac_idx;
    logic                   frame_end;

    // CRC feed
    logic [7:0]             cov_byte;
    logic                   cov_vld;
    logic [31:0]            fcs;
    logic                   fcs_vld;
    logic                   pay_last;

    // length strobe shares the last-byte pulse
    assign o_pay_last    = pay_last;
    assign o_pay_len_vld = pay_last;

    frame_sync u_frame_sync (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_rx_data       (i_rx_data),
        .i_rx_valid      (i_rx_valid),
        .o_mac_byte      (mac_byte),
        .o_mac_vld       (mac_vld),
        .o_mac_idx       (mac_idx),
        .o_frame_end     (frame_end),
        .o_delim         (o_delim),
        .o_delim_vld     (o_delim_vld),
        .o_frag_cnt      (o_frag_cnt),
        .o_frag_vld      (o_frag_vld),
        .o_rx_frames_cnt (o_rx_frames_cnt)
    );

    header_extract u_header_extract (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_mac_byte (mac_byte),
        .i_mac_vld  (mac_vld),
        .i_mac_idx  (mac_idx),
        .o_dst_mac  (o_dst_mac),
        .o_dst_vld  (o_dst_vld),
        .o_src_mac  (o_src_mac),
        .o_src_vld  (o_src_vld),
        .o_eth_type (o_eth_type),
        .o_type_vld (o_type_vld)
    );

    fcs_strip u_fcs_strip (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_mac_byte  (mac_byte),
        .i_mac_vld   (mac_vld),
        .i_mac_idx   (mac_idx),
        .i_frame_end (frame_end),
        .o_cov_byte  (cov_byte),
        .o_cov_vld   (cov_vld),
        .o_fcs       (fcs),
        .o_fcs_vld   (fcs_vld),
        .o_pay_data  (o_pay_data),
        .o_pay_vld   (o_pay_vld),
        .o_pay_last  (pay_last),
        .o_pay_len   (o_pay_len)
    );

    fcs_check u_fcs_check (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_cov_byte    (cov_byte),
        .i_cov_vld     (cov_vld),
        .i_fcs         (fcs),
        .i_fcs_vld     (fcs_vld),
        .o_crc_kind    (o_crc_kind),
        .o_crc_err     (o_crc_err),
        .o_err_crc_cnt (o_err_crc_cnt)
    );

endmodule

// ==== src/fcs_check.sv ====
`timescale 1ns/10ps
`include "eth_rx_defines.svh"

module fcs_check import eth_rx_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [7:0]          i_cov_byte,
    input  logic                i_cov_vld,
    input  logic [31:0]         i_fcs,
    input  logic                i_fcs_vld,
    output crc_kind_e           o_crc_kind,
    output logic                o_crc_err,
    output logic [`CNT_W-1:0]   o_err_crc_cnt
);

    logic [31:0]    crc;
    logic [31:0]    crc_final;
    logic           fcs_ok;
    logic           mcrc_ok;

    ////////////////////////////////////////////////////////////
    // reflected CRC-32 stepped one byte per call
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] crc_next(input logic [31:0] c_in, input logic [7:0] d);
        logic [31:0] c;
        logic        fb;
        c = c_in;
        // lsb of the data byte goes first
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ `CRC_POLY_REFL;
            end
        end
        return c;
    endfunction

    // transmitted FCS is the complemented register
    assign crc_final = ~crc;
    assign fcs_ok    = (i_fcs == crc_final);
    assign mcrc_ok   = (i_fcs == (crc_final ^ `MCRC_XOR));

    ////////////////////////////////////////////////////////////
    // accumulate and judge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            crc           <= `CRC_INIT;
            o_crc_kind    <= CRC_NONE;
            o_crc_err     <= 1'b0;
            o_err_crc_cnt <= '0;
        end
        else begin
            o_crc_kind <= CRC_NONE;
            o_crc_err  <= 1'b0;
            if (i_fcs_vld) begin
                // fresh seed for the next frame
                crc <= `CRC_INIT;
                if (fcs_ok) begin
                    o_crc_kind <= CRC_FINAL;
                end
                else if (mcrc_ok) begin
                    o_crc_kind <= CRC_MCRC;
                end
                else begin
                    o_crc_err     <= 1'b1;
                    o_err_crc_cnt <= o_err_crc_cnt + 1'b1;
                end
            end
            else if (i_cov_vld) begin
                crc <= crc_next(crc, i_cov_byte);
            end
        end
    end

endmodule

// ==== src/fcs_strip.sv ====
`timescale 1ns/10ps
`include "eth_rx_defines.svh"

module fcs_strip (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [7:0]          i_mac_byte,
    input  logic                i_mac_vld,
    input  logic [`CNT_W-1:0]   i_mac_idx,
    input  logic                i_frame_end,
    output logic [7:0]          o_cov_byte,
    output logic                o_cov_vld,
    output logic [31:0]         o_fcs,
    output logic                o_fcs_vld,
    output logic [7:0]          o_pay_data,
    output logic                o_pay_vld,
    output logic                o_pay_last,
    output logic [`CNT_W-1:0]   o_pay_len
);

    // four FCS bytes plus the newest payload candidate
    localparam int DEPTH = `FCS_BYTES + 1;
    localparam logic [2:0] FULL = 3'(DEPTH);
    localparam logic [`CNT_W-1:0] PAY_FIRST = `CNT_W'(`HDR_BYTES);

    logic [7:0]             line_byte [DEPTH];
    logic [`CNT_W-1:0]      line_idx [DEPTH];
    logic [2:0]             fill;
    logic [`CNT_W-1:0]      pay_cnt;
    logic                   end_d;
    logic                   push_out;
    logic                   out_is_pay;

    // oldest byte leaves once a newer one pushes it out
    assign push_out   = i_mac_vld && (fill == FULL);
    assign out_is_pay = line_idx[DEPTH-1] >= PAY_FIRST;

    ////////////////////////////////////////////////////////////
    // hold-back line
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_mac_vld) begin
            line_byte[0] <= i_mac_byte;
            line_idx[0]  <= i_mac_idx;
            for (int i = 1; i < DEPTH; i++) begin
                line_byte[i] <= line_byte[i-1];
                line_idx[i]  <= line_idx[i-1];
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            fill       <= '0;
            pay_cnt    <= '0;
            end_d      <= 1'b0;
            o_cov_vld  <= 1'b0;
            o_pay_vld  <= 1'b0;
            o_pay_last <= 1'b0;
            o_fcs_vld  <= 1'b0;
        end
        else begin
            if (i_frame_end) begin
                fill    <= '0;
                pay_cnt <= '0;
            end
            else begin
                if (i_mac_vld && fill != FULL) begin
                    fill <= fill + 3'd1;
                end
                if (push_out && out_is_pay) begin
                    pay_cnt <= pay_cnt + 1'b1;
                end
            end
            o_cov_vld  <= push_out || i_frame_end;
            o_pay_vld  <= (push_out && out_is_pay) || i_frame_end;
            o_pay_last <= i_frame_end;
            // FCS follows the last covered byte by one cycle
            end_d      <= i_frame_end;
            o_fcs_vld  <= end_d;
        end
    end

    // at frame end the oldest entry is the final payload byte
    always_ff @(posedge i_clk) begin
        if (push_out || i_frame_end) begin
            o_cov_byte <= line_byte[DEPTH-1];
            o_pay_data <= line_byte[DEPTH-1];
        end
        if (i_frame_end) begin
            o_pay_len <= pay_cnt + 1'b1;
            o_fcs     <= {line_byte[0], line_byte[1], line_byte[2], line_byte[3]};
        end
    end

endmodule

// ==== src/frame_sync.sv ====
`timescale 1ns/10ps
`include "eth_rx_defines.svh"

module frame_sync import eth_rx_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [7:0]          i_rx_data,
    input  logic                i_rx_valid,
    output logic [7:0]          o_mac_byte,
    output logic                o_mac_vld,
    output logic [`CNT_W-1:0]   o_mac_idx,
    output logic                o_frame_end,
    output logic [7:0]          o_delim,
    output logic                o_delim_vld,
    output logic [7:0]          o_frag_cnt,
    output logic                o_frag_vld,
    output logic [`CNT_W-1:0]   o_rx_frames_cnt
);

    localparam logic [2:0] PRE_FULL = 3'(`PREAMBLE_MIN);

    rx_state_e              state;
    logic [2:0]             pre_cnt;
    logic [`CNT_W-1:0]      idx;
    logic                   valid_d;
    logic                   delim_hit;
    logic                   frag_hit;
    logic                   mac_hit;

    function automatic logic is_smd_s(input logic [7:0] b);
        return (b == `SMD_S0) || (b == `SMD_S1) || (b == `SMD_S2) || (b == `SMD_S3);
    endfunction

    function automatic logic is_smd_c(input logic [7:0] b);
        return (b == `SMD_C0) || (b == `SMD_C1) || (b == `SMD_C2) || (b == `SMD_C3);
    endfunction

    ////////////////////////////////////////////////////////////
    // delimiter decode
    ////////////////////////////////////////////////////////////
    // byte 7 may only be a continuation code, byte 8 sfd or a start code
    always_comb begin
        delim_hit = 1'b0;
        if (i_rx_valid) begin
            if (state == PREAMBLE && pre_cnt == PRE_FULL) begin
                delim_hit = is_smd_c(i_rx_data);
            end
            else if (state == PRE_LAST) begin
                delim_hit = is_smd_s(i_rx_data) || (i_rx_data == `SFD_BYTE);
            end
        end
    end

    assign frag_hit = i_rx_valid && (state == FRAG);
    assign mac_hit  = i_rx_valid && (state == MAC_BODY);

    ////////////////////////////////////////////////////////////
    // framing FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state   <= IDLE;
            pre_cnt <= '0;
        end
        else if (!i_rx_valid) begin
            state   <= IDLE;
            pre_cnt <= '0;
        end
        else begin
            case (state)
                IDLE: begin
                    pre_cnt <= 3'd1;
                    state   <= (i_rx_data == `PREAMBLE_BYTE) ? PREAMBLE : DISCARD;
                end
                PREAMBLE: begin
                    if (pre_cnt != PRE_FULL) begin
                        if (i_rx_data == `PREAMBLE_BYTE) begin
                            pre_cnt <= pre_cnt + 3'd1;
                        end
                        else begin
                            state <= DISCARD;
                        end
                    end
                    else if (i_rx_data == `PREAMBLE_BYTE) begin
                        state <= PRE_LAST;
                    end
                    else begin
                        state <= delim_hit ? FRAG : DISCARD;
                    end
                end
                PRE_LAST: begin
                    state <= delim_hit ? MAC_BODY : DISCARD;
                end
                FRAG: begin
                    state <= MAC_BODY;
                end
                // body and discard run until valid drops
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    // strobes, byte index and frame counter
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_mac_vld       <= 1'b0;
            o_frame_end     <= 1'b0;
            o_delim_vld     <= 1'b0;
            o_frag_vld      <= 1'b0;
            idx             <= '0;
            valid_d         <= 1'b0;
            o_rx_frames_cnt <= '0;
        end
        else begin
            o_mac_vld   <= mac_hit;
            o_frame_end <= (state == MAC_BODY) && !i_rx_valid;
            o_delim_vld <= delim_hit;
            o_frag_vld  <= frag_hit;
            idx         <= mac_hit ? idx + 1'b1 : '0;
            valid_d     <= i_rx_valid;
            if (i_rx_valid && !valid_d) begin
                o_rx_frames_cnt <= o_rx_frames_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (mac_hit) begin
            o_mac_byte <= i_rx_data;
            o_mac_idx  <= idx;
        end
        if (delim_hit) begin
            o_delim <= i_rx_data;
        end
        if (frag_hit) begin
            o_frag_cnt <= i_rx_data;
        end
    end

endmodule

// ==== src/header_extract.sv ====
`timescale 1ns/10ps
`include "eth_rx_defines.svh"

module header_extract (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [7:0]          i_mac_byte,
    input  logic                i_mac_vld,
    input  logic [`CNT_W-1:0]   i_mac_idx,
    output logic [47:0]         o_dst_mac,
    output logic                o_dst_vld,
    output logic [47:0]         o_src_mac,
    output logic                o_src_vld,
    output logic [15:0]         o_eth_type,
    output logic                o_type_vld
);

    // index of the last byte of each field
    localparam logic [`CNT_W-1:0] DST_END  = `CNT_W'(`MAC_BYTES - 1);
    localparam logic [`CNT_W-1:0] SRC_END  = `CNT_W'(2 * `MAC_BYTES - 1);
    localparam logic [`CNT_W-1:0] TYPE_END = `CNT_W'(`HDR_BYTES - 1);

    ////////////////////////////////////////////////////////////
    // field shift registers
    ////////////////////////////////////////////////////////////
    // first byte on the wire ends up most significant
    always_ff @(posedge i_clk) begin
        if (i_mac_vld) begin
            if (i_mac_idx <= DST_END) begin
                o_dst_mac <= {o_dst_mac[39:0], i_mac_byte};
            end
            else if (i_mac_idx <= SRC_END) begin
                o_src_mac <= {o_src_mac[39:0], i_mac_byte};
            end
            else if (i_mac_idx <= TYPE_END) begin
                o_eth_type <= {o_eth_type[7:0], i_mac_byte};
            end
        end
    end

    // field done strobes
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_dst_vld  <= 1'b0;
            o_src_vld  <= 1'b0;
            o_type_vld <= 1'b0;
        end
        else begin
            o_dst_vld  <= i_mac_vld && (i_mac_idx == DST_END);
            o_src_vld  <= i_mac_vld && (i_mac_idx == SRC_END);
            o_type_vld <= i_mac_vld && (i_mac_idx == TYPE_END);
        end
    end

endmodule

// ==== test/eth_rx_tb_tasks.svh ====
`ifndef ETH_RX_TB_TASKS_SVH
`define ETH_RX_TB_TASKS_SVH

localparam int FCS_GOOD = 0;
localparam int FCS_MCRC = 1;
localparam int FCS_BAD  = 2;

// reflected CRC-32 over mac_q returned as the FCS to send
function automatic logic [31:0] crc_of_frame();
    logic [31:0] c;
    c = `CRC_INIT;
    foreach (mac_q[i]) begin
        c = c ^ {24'h0, mac_q[i]};
        repeat (8) begin
            c = c[0] ? ((c >> 1) ^ `CRC_POLY_REFL) : (c >> 1);
        end
    end
    return ~c;
endfunction

////////////////////////////////////////////////////////////
// frame builder
////////////////////////////////////////////////////////////
task automatic build_frame(input logic [7:0] delim, input logic [7:0] frag,
                           input int pay_len, input int fcs_mode, input bit expect_out);
    logic [47:0] dst;
    logic [47:0] src;
    logic [15:0] eth_type;
    logic [7:0]  b;
    logic [31:0] fcs;
    bit          cont;
    int          pre_len;
    tx_q.delete();
    mac_q.delete();
    dst      = {16'($urandom), $urandom};
    src      = {16'($urandom), $urandom};
    eth_type = 16'($urandom);
    cont     = delim inside {`SMD_C0, `SMD_C1, `SMD_C2, `SMD_C3};
    // a continuation code sits where the last 0x55 would be
    pre_len  = cont ? `PREAMBLE_MIN : `PREAMBLE_MIN + 1;
    for (int i = 0; i < pre_len; i++) begin
        tx_q.push_back(`PREAMBLE_BYTE);
    end
    tx_q.push_back(delim);
    if (cont) begin
        tx_q.push_back(frag);
    end
    for (int i = 5; i >= 0; i--) begin
        mac_q.push_back(dst[8*i +: 8]);
    end
    for (int i = 5; i >= 0; i--) begin
        mac_q.push_back(src[8*i +: 8]);
    end
    mac_q.push_back(eth_type[15:8]);
    mac_q.push_back(eth_type[7:0]);
    for (int i = 0; i < pay_len; i++) begin
        b = 8'($urandom);
        mac_q.push_back(b);
        if (expect_out) begin
            exp_pay.push_back({i == pay_len - 1, b});
        end
    end
    fcs = crc_of_frame();
    if (fcs_mode == FCS_MCRC) begin
        fcs = fcs ^ `MCRC_XOR;
    end
    else if (fcs_mode == FCS_BAD) begin
        fcs = fcs ^ 32'h0000_FF00;
    end
    foreach (mac_q[i]) begin
        tx_q.push_back(mac_q[i]);
    end
    // FCS goes out least significant byte first
    for (int i = 0; i < `FCS_BYTES; i++) begin
        tx_q.push_back(fcs[8*i +: 8]);
    end
    if (expect_out) begin
        exp_delim.push_back(delim);
        if (cont) begin
            exp_frag.push_back(frag);
        end
        exp_dst.push_back(dst);
        exp_src.push_back(src);
        exp_type.push_back(eth_type);
        exp_len.push_back(`CNT_W'(pay_len));
        case (fcs_mode)
            FCS_MCRC: exp_verdict.push_back({1'b0, CRC_MCRC});
            FCS_BAD:  exp_verdict.push_back({1'b1, CRC_NONE});
            default:  exp_verdict.push_back({1'b0, CRC_FINAL});
        endcase
        if (fcs_mode == FCS_BAD) begin
            corrupt_sent++;
        end
    end
endtask

// one byte per clock with valid held for the whole frame
task automatic send_frame();
    foreach (tx_q[i]) begin
        @(posedge i_clk);
        i_rx_data  <= tx_q[i];
        i_rx_valid <= 1'b1;
    end
    @(posedge i_clk);
    i_rx_valid <= 1'b0;
    i_rx_data  <= 8'h00;
    // inter-frame gap
    repeat (3) @(posedge i_clk);
    frames_sent++;
endtask

function automatic bit queues_empty();
    return (exp_delim.size() + exp_frag.size() + exp_dst.size() + exp_src.size()
            + exp_type.size() + exp_pay.size() + exp_len.size() + exp_verdict.size()) == 0;
endfunction

task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (!queues_empty() && n < 200) begin
        @(negedge i_clk);
        n++;
    end
    if (!queues_empty()) begin
        $display("timeout: %s still had outputs missing after 200 cycles", what);
        err_cnt++;
        exp_delim.delete();
        exp_frag.delete();
        exp_dst.delete();
        exp_src.delete();
        exp_type.delete();
        exp_pay.delete();
        exp_len.delete();
        exp_verdict.delete();
    end
endtask

task automatic wait_frames();
    int n;
    n = 0;
    while (o_rx_frames_cnt != `CNT_W'(frames_sent) && n < 200) begin
        @(negedge i_clk);
        n++;
    end
    if (o_rx_frames_cnt != `CNT_W'(frames_sent)) begin
        $display("timeout: frame counter stayed at %0d with %0d frames sent",
                 o_rx_frames_cnt, frames_sent);
        err_cnt++;
    end
endtask

task automatic finish_test(input string name);
    $display("%s: %s", name, (err_cnt == err_mark) ? "passed" : "failed");
    test_cnt++;
    err_mark = err_cnt;
endtask

`endif

// ==== test/eth_rx_tb.sv ====
`timescale 1ns/10ps
`include "eth_rx_defines.svh"

module eth_rx_tb import eth_rx_pkg::*; ();

    logic                   i_clk;
    logic                   i_rst;
    logic [7:0]             i_rx_data;
    logic                   i_rx_valid;
    logic [47:0]            o_dst_mac;
    logic                   o_dst_vld;
    logic [47:0]            o_src_mac;
    logic                   o_src_vld;
    logic [15:0]            o_eth_type;
    logic                   o_type_vld;
    logic [7:0]             o_delim;
    logic                   o_delim_vld;
    logic [7:0]             o_frag_cnt;
    logic                   o_frag_vld;
    logic [7:0]             o_pay_data;
    logic                   o_pay_vld;
    logic                   o_pay_last;
    logic [`CNT_W-1:0]      o_pay_len;
    logic                   o_pay_len_vld;
    crc_kind_e              o_crc_kind;
    logic                   o_crc_err;
    logic [`CNT_W-1:0]      o_rx_frames_cnt;
    logic [`CNT_W-1:0]      o_err_crc_cnt;

    // wire bytes of the frame being sent and its MAC-layer part
    logic [7:0]             tx_q[$];
    logic [7:0]             mac_q[$];
    // expected outputs in arrival order
    logic [7:0]             exp_delim[$];
    logic [7:0]             exp_frag[$];
    logic [47:0]            exp_dst[$];
    logic [47:0]            exp_src[$];
    logic [15:0]            exp_type[$];
    logic [8:0]             exp_pay[$];
    logic [`CNT_W-1:0]      exp_len[$];
    logic [2:0]             exp_verdict[$];

    int                     err_cnt = 0;
    int                     err_mark = 0;
    int                     check_cnt = 0;
    int                     test_cnt = 0;
    int                     frames_sent = 0;
    int                     corrupt_sent = 0;

    `include "eth_rx_tb_tasks.svh"

    eth_rx_top i_dut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_rx_data       (i_rx_data),
        .i_rx_valid      (i_rx_valid),
        .o_dst_mac       (o_dst_mac),
        .o_dst_vld       (o_dst_vld),
        .o_src_mac       (o_src_mac),
        .o_src_vld       (o_src_vld),
        .o_eth_type      (o_eth_type),
        .o_type_vld      (o_type_vld),
        .o_delim         (o_delim),
        .o_delim_vld     (o_delim_vld),
        .o_frag_cnt      (o_frag_cnt),
        .o_frag_vld      (o_frag_vld),
        .o_pay_data      (o_pay_data),
        .o_pay_vld       (o_pay_vld),
        .o_pay_last      (o_pay_last),
        .o_pay_len       (o_pay_len),
        .o_pay_len_vld   (o_pay_len_vld),
        .o_crc_kind      (o_crc_kind),
        .o_crc_err       (o_crc_err),
        .o_rx_frames_cnt (o_rx_frames_cnt),
        .o_err_crc_cnt   (o_err_crc_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #50 i_clk = ~i_clk;
        end
    end

    task automatic log_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        err_cnt++;
    endtask

    ////////////////////////////////////////////////////////////
    // output checks
    ////////////////////////////////////////////////////////////
    assert property (@(posedge i_clk) disable iff (i_rst) o_crc_err |-> o_crc_kind == CRC_NONE)
        else log_error("error strobe comes with a crc kind");

    // each strobe must match the head of its queue
    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (o_delim_vld) begin
                check_cnt++;
                assert (exp_delim.size() != 0 && o_delim == exp_delim[0])
                    else log_error($sformatf("delimiter 0x%02h not expected", o_delim));
                if (exp_delim.size() != 0) begin
                    exp_delim.delete(0);
                end
            end
            if (o_frag_vld) begin
                check_cnt++;
                assert (exp_frag.size() != 0 && o_frag_cnt == exp_frag[0])
                    else log_error($sformatf("fragment count %0d not expected", o_frag_cnt));
                if (exp_frag.size() != 0) begin
                    exp_frag.delete(0);
                end
            end
            if (o_dst_vld) begin
                check_cnt++;
                assert (exp_dst.size() != 0 && o_dst_mac == exp_dst[0])
                    else log_error($sformatf("destination %012h not expected", o_dst_mac));
                if (exp_dst.size() != 0) begin
                    exp_dst.delete(0);
                end
            end
            if (o_src_vld) begin
                check_cnt++;
                assert (exp_src.size() != 0 && o_src_mac == exp_src[0])
                    else log_error($sformatf("source %012h not expected", o_src_mac));
                if (exp_src.size() != 0) begin
                    exp_src.delete(0);
                end
            end
            if (o_type_vld) begin
                check_cnt++;
                assert (exp_type.size() != 0 && o_eth_type == exp_type[0])
                    else log_error($sformatf("type %04h not expected", o_eth_type));
                if (exp_type.size() != 0) begin
                    exp_type.delete(0);
                end
            end
            if (o_pay_vld) begin
                check_cnt++;
                assert (exp_pay.size() != 0 && {o_pay_last, o_pay_data} == exp_pay[0])
                    else log_error($sformatf("payload %02h last %0b not expected",
                                             o_pay_data, o_pay_last));
                if (exp_pay.size() != 0) begin
                    exp_pay.delete(0);
                end
            end
            if (o_pay_len_vld) begin
                check_cnt++;
                assert (exp_len.size() != 0 && o_pay_len == exp_len[0])
                    else log_error($sformatf("payload length %0d not expected", o_pay_len));
                if (exp_len.size() != 0) begin
                    exp_len.delete(0);
                end
            end
            if (o_crc_err || o_crc_kind != CRC_NONE) begin
                check_cnt++;
                assert (exp_verdict.size() != 0 && {o_crc_err, o_crc_kind} == exp_verdict[0])
                    else log_error($sformatf("verdict kind %0d err %0b not expected",
                                             o_crc_kind, o_crc_err));
                if (exp_verdict.size() != 0) begin
                    exp_verdict.delete(0);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(47));
        i_rst      = 1'b1;
        i_rx_data  = 8'h00;
        i_rx_valid = 1'b0;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (2) @(posedge i_clk);

        build_frame(`SFD_BYTE, 8'h00, 20, FCS_GOOD, 1'b1);
        send_frame();
        wait_drained("sfd frame");
        finish_test("test 1 sfd frame fields and verdict");

        repeat (5) begin
            build_frame(`SFD_BYTE, 8'h00, 1 + int'($urandom % 40), FCS_GOOD, 1'b1);
            send_frame();
            wait_drained("random payload frame");
        end
        finish_test("test 2 random length payloads");

        // express start with a fragment marker, then a continuation
        build_frame(`SMD_S2, 8'h00, 12, FCS_MCRC, 1'b1);
        send_frame();
        wait_drained("smd-s frame");
        build_frame(`SMD_C1, 8'h03, 9, FCS_GOOD, 1'b1);
        send_frame();
        wait_drained("smd-c frame");
        finish_test("test 3 preemption delimiters");

        build_frame(`SFD_BYTE, 8'h00, 16, FCS_BAD, 1'b1);
        send_frame();
        wait_drained("corrupted frame");
        check_cnt++;
        assert (o_err_crc_cnt == `CNT_W'(corrupt_sent))
            else log_error($sformatf("crc error count %0d after bad frame", o_err_crc_cnt));
        finish_test("test 4 corrupted fcs");

        build_frame(`SFD_BYTE, 8'h00, 10, FCS_GOOD, 1'b0);
        tx_q[3] = 8'h57;
        send_frame();
        wait_frames();
        build_frame(8'h12, 8'h00, 10, FCS_GOOD, 1'b0);
        send_frame();
        wait_frames();
        // a clean frame behind the discards flushes any late pulse
        build_frame(`SFD_BYTE, 8'h00, 10, FCS_GOOD, 1'b1);
        send_frame();
        wait_drained("discarded frames");
        finish_test("test 5 discarded frames");

        check_cnt += 2;
        assert (o_rx_frames_cnt == `CNT_W'(frames_sent))
            else log_error($sformatf("frame count %0d, %0d sent", o_rx_frames_cnt, frames_sent));
        assert (o_err_crc_cnt == `CNT_W'(corrupt_sent))
            else log_error($sformatf("crc error count %0d, %0d corrupted",
                                     o_err_crc_cnt, corrupt_sent));
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
